/* include/dataflow_consts.svh */
`ifndef DATAFLOW_CONSTS_SVH
`define DATAFLOW_CONSTS_SVH

// bus and register width
`define DATA_WIDTH 8
`define FLAG_COUNT 21
// value of an undriven bus
`define PRECHARGE_VALUE 8'hFF

// data bus sources
`define SET_DB_TO_DATA 0
`define SET_DB_TO_ACC 1
`define SET_DB_TO_ALU 2
// special bus sources
`define SET_SB_TO_X 3
`define SET_SB_TO_ACC 4
`define SET_SB_TO_ADH 5
`define SET_SB_TO_DB 6
// address high bus sources
`define SET_ADH_TO_DATA 7
`define SET_ADH_FF 8
`define SET_ADH_TO_SB 9
// address low bus sources
`define SET_ADL_TO_DB 10
`define SET_ADL_TO_SB 11
// register load enables
`define LOAD_X 12
`define LOAD_ACC 13
`define LOAD_ABH 14
`define LOAD_ABL 15
// alu operation select, priority order
`define ALU_SUM 16
`define ALU_AND 17
`define ALU_OR 18
`define ALU_XOR 19
`define ALU_CARRY_IN 20

`endif

/* source/dataflowPkg.sv */
`include "dataflow_consts.svh"

package dataflowPkg;

  // one byte on any internal bus
  typedef logic [`DATA_WIDTH-1:0] busByteT;

  // control flags, one bit per flag index
  typedef logic [`FLAG_COUNT-1:0] flagVecT;

  // alu operation after priority decode
  typedef enum logic [2:0] {
    NONE,
    SUM,
    AND,
    OR,
    XOR
  } aluOpT;

endpackage

/* source/interruptPkg.sv */
package interruptPkg;

  // acknowledgement state machine
  typedef enum logic [1:0] {
    RESET_PENDING,
    IDLE,
    NMI_PENDING,
    IRQ_PENDING
  } injStateT;

  // kind of request waiting for the next ack
  typedef logic [1:0] intKindT;

  localparam intKindT KIND_NONE = 2'd0;
  localparam intKindT KIND_RESET = 2'd1;
  localparam intKindT KIND_NMI = 2'd2;
  localparam intKindT KIND_IRQ = 2'd3;

endpackage

/* source/internalBus.sv */
`timescale 1ns/1ps

`include "dataflow_consts.svh"

module internalBus
  import dataflowPkg::*;
(
  input  flagVecT flags,
  input  busByteT extData,
  input  busByteT xReg,
  input  busByteT accReg,
  input  busByteT aluHold,
  output busByteT dataBus,
  output busByteT specialBus,
  output busByteT addrHighBus,
  output busByteT addrLowBus
);

  // special bus value from its non-adh sources
  busByteT sbCore;
  logic sbFromAdh;
  logic adhFromSb;
  logic routeLoop;

  // data bus, lowest flag index wins
  always_comb begin
    if (flags[`SET_DB_TO_DATA]) dataBus = extData;
    else if (flags[`SET_DB_TO_ACC]) dataBus = accReg;
    else if (flags[`SET_DB_TO_ALU]) dataBus = aluHold;
    else dataBus = `PRECHARGE_VALUE;
  end

  // winning source checks for the sb/adh pair
  assign sbFromAdh = flags[`SET_SB_TO_ADH] & ~flags[`SET_SB_TO_X] & ~flags[`SET_SB_TO_ACC];
  assign adhFromSb = flags[`SET_ADH_TO_SB] & ~flags[`SET_ADH_TO_DATA] & ~flags[`SET_ADH_FF];
  // each bus fed from the other, no real driver
  assign routeLoop = sbFromAdh & adhFromSb;

  // sb without the adh path
  // when sbFromAdh wins this value is never used
  always_comb begin
    if (flags[`SET_SB_TO_X]) sbCore = xReg;
    else if (flags[`SET_SB_TO_ACC]) sbCore = accReg;
    else if (flags[`SET_SB_TO_DB]) sbCore = dataBus;
    else sbCore = `PRECHARGE_VALUE;
  end

  // address high bus
  always_comb begin
    if (flags[`SET_ADH_TO_DATA]) addrHighBus = extData;
    else if (flags[`SET_ADH_FF]) addrHighBus = 8'hFF;
    // loop resolves to precharge
    else if (adhFromSb) addrHighBus = routeLoop ? `PRECHARGE_VALUE : sbCore;
    else addrHighBus = `PRECHARGE_VALUE;
  end

  assign specialBus = sbFromAdh ? addrHighBus : sbCore;

  // address low bus
  always_comb begin
    if (flags[`SET_ADL_TO_DB]) addrLowBus = dataBus;
    else if (flags[`SET_ADL_TO_SB]) addrLowBus = specialBus;
    else addrLowBus = `PRECHARGE_VALUE;
  end

endmodule

/* source/registerBlock.sv */
`timescale 1ns/1ps

`include "dataflow_consts.svh"

module registerBlock
  import dataflowPkg::*;
(
  input  logic hwclk,
  input  logic rstN,
  input  flagVecT flags,
  input  busByteT dataBus,
  input  busByteT specialBus,
  input  busByteT addrHighBus,
  input  busByteT addrLowBus,
  output busByteT xReg,
  output busByteT accReg,
  output busByteT abh,
  output busByteT abl,
  output busByteT dor
);

  // index register
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      xReg <= '0;
    end else if (flags[`LOAD_X]) begin
      xReg <= specialBus;
    end
  end

  // accumulator, also from sb
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      accReg <= '0;
    end else if (flags[`LOAD_ACC]) begin
      accReg <= specialBus;
    end
  end

  // address bus high register
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      abh <= '0;
    end else if (flags[`LOAD_ABH]) begin
      abh <= addrHighBus;
    end
  end

  // address bus low register
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      abl <= '0;
    end else if (flags[`LOAD_ABL]) begin
      abl <= addrLowBus;
    end
  end

  // data output register
  // follows db unless db is reading external data
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      dor <= '0;
    end else if (!flags[`SET_DB_TO_DATA]) begin
      dor <= dataBus;
    end
  end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

`include "dataflow_consts.svh"

module alu
  import dataflowPkg::*;
(
  input  logic hwclk,
  input  logic rstN,
  input  flagVecT flags,
  input  busByteT specialBus,
  input  busByteT dataBus,
  output busByteT aluHold,
  output logic carry
);

  aluOpT aluOp;
  busByteT result;
  logic carryOut;
  // sum with carry out in the top bit
  logic [`DATA_WIDTH:0] sumWide;

  // priority decode, sum first
  always_comb begin
    if (flags[`ALU_SUM]) aluOp = SUM;
    else if (flags[`ALU_AND]) aluOp = AND;
    else if (flags[`ALU_OR]) aluOp = OR;
    else if (flags[`ALU_XOR]) aluOp = XOR;
    else aluOp = NONE;
  end

  assign sumWide = {1'b0, specialBus} + {1'b0, dataBus}
    + {{`DATA_WIDTH{1'b0}}, flags[`ALU_CARRY_IN]};

  // logic ops clear the carry
  always_comb begin
    result = aluHold;
    carryOut = carry;
    case (aluOp)
      SUM: begin
        result = sumWide[`DATA_WIDTH-1:0];
        carryOut = sumWide[`DATA_WIDTH];
      end
      AND: begin
        result = specialBus & dataBus;
        carryOut = 1'b0;
      end
      OR: begin
        result = specialBus | dataBus;
        carryOut = 1'b0;
      end
      XOR: begin
        result = specialBus ^ dataBus;
        carryOut = 1'b0;
      end
      default: begin
        // hold on no operation
        result = aluHold;
        carryOut = carry;
      end
    endcase
  end

  // hold register, result visible on db next cycle
  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      aluHold <= '0;
      carry <= 1'b0;
    end else begin
      aluHold <= result;
      carry <= carryOut;
    end
  end

endmodule

/* source/internalDataflow.sv */
`timescale 1ns/1ps

`include "dataflow_consts.svh"

module internalDataflow
  import dataflowPkg::*;
(
  input  logic hwclk,
  input  logic rstN,
  input  flagVecT flags,
  input  busByteT externalDBRead,
  output busByteT externalAddressBusHighOutput,
  output busByteT externalAddressBusLowOutput,
  output busByteT externalDBWrite,
  output logic carry,
  output logic accSign
);

  // the four shared buses
  busByteT dataBus;
  busByteT specialBus;
  busByteT addrHighBus;
  busByteT addrLowBus;

  // register and alu values fed back to the arbiter
  busByteT xReg;
  busByteT accReg;
  busByteT aluHold;

  internalBus busArbiter (
    .flags(flags),
    .extData(externalDBRead),
    .xReg(xReg),
    .accReg(accReg),
    .aluHold(aluHold),
    .dataBus(dataBus),
    .specialBus(specialBus),
    .addrHighBus(addrHighBus),
    .addrLowBus(addrLowBus)
  );

  registerBlock registers (
    .hwclk(hwclk),
    .rstN(rstN),
    .flags(flags),
    .dataBus(dataBus),
    .specialBus(specialBus),
    .addrHighBus(addrHighBus),
    .addrLowBus(addrLowBus),
    .xReg(xReg),
    .accReg(accReg),
    .abh(externalAddressBusHighOutput),
    .abl(externalAddressBusLowOutput),
    .dor(externalDBWrite)
  );

  // alu takes sb and db
  alu aluUnit (
    .hwclk(hwclk),
    .rstN(rstN),
    .flags(flags),
    .specialBus(specialBus),
    .dataBus(dataBus),
    .aluHold(aluHold),
    .carry(carry)
  );

  // negative flag source
  assign accSign = accReg[`DATA_WIDTH-1];

endmodule

/* source/interruptInjector.sv */
`timescale 1ns/1ps

module interruptInjector
  import interruptPkg::*;
(
  input  logic hwclk,
  input  logic rstN,
  input  logic nonMaskableInterrupt,
  input  logic interruptRequest,
  input  logic processStatusRegIFlag,
  input  logic interruptAcknowledged,
  output logic irqGenerated,
  output logic nmiGenerated,
  output logic nmiRunning,
  output logic resetRunning
);

  injStateT state;
  injStateT nextState;
  intKindT pendingKind;
  // last sampled nmi level for edge detect
  logic nmiPrev;
  logic nmiEdge;
  logic takeNmi;

  // irq masked by the i flag, any state
  assign irqGenerated = interruptRequest & ~processStatusRegIFlag;
  assign resetRunning = (state == RESET_PENDING);
  assign nmiEdge = nonMaskableInterrupt & ~nmiPrev;

  // which request the next ack serves
  always_comb begin
    if (state == RESET_PENDING) pendingKind = KIND_RESET;
    else if (state != IDLE) pendingKind = KIND_NONE;
    else if (nmiGenerated) pendingKind = KIND_NMI;
    else if (irqGenerated) pendingKind = KIND_IRQ;
    else pendingKind = KIND_NONE;
  end

  // ack moves forward one step
  always_comb begin
    nextState = state;
    if (interruptAcknowledged) begin
      case (state)
        RESET_PENDING: nextState = IDLE;
        IDLE: begin
          if (pendingKind == KIND_NMI) nextState = NMI_PENDING;
          else if (pendingKind == KIND_IRQ) nextState = IRQ_PENDING;
        end
        default: nextState = IDLE;
      endcase
    end
  end

  assign takeNmi = interruptAcknowledged & (pendingKind == KIND_NMI);

  always_ff @(posedge hwclk or negedge rstN) begin
    if (!rstN) begin
      state <= RESET_PENDING;
      nmiPrev <= 1'b0;
      nmiGenerated <= 1'b0;
      nmiRunning <= 1'b0;
    end else begin
      state <= nextState;
      nmiPrev <= nonMaskableInterrupt;
      // new edge wins over a same-cycle clear
      if (nmiEdge) nmiGenerated <= 1'b1;
      else if (takeNmi) nmiGenerated <= 1'b0;
      // running from nmi ack until the closing ack
      if (takeNmi) begin
        nmiRunning <= 1'b1;
      end else if (interruptAcknowledged && (state == NMI_PENDING || state == IRQ_PENDING)) begin
        nmiRunning <= 1'b0;
      end
    end
  end

endmodule

/* source/top.sv */
`timescale 1ns/1ps

`include "dataflow_consts.svh"

module top
  import dataflowPkg::*;
(
  input  logic hwclk,
  input  logic rstN,
  input  logic [`FLAG_COUNT-1:0] pb,
  input  busByteT rxdata,
  input  logic nmi,
  input  logic irq,
  input  logic iFlag,
  input  logic ack,
  output busByteT left,
  output busByteT right,
  output busByteT txdata,
  output logic red,
  output logic green,
  output logic blue,
  output logic irqGenerated,
  output logic nmiGenerated,
  output logic nmiRunning
);

  flagVecT flags;

  // one button per flag, same index
  always_comb begin
    flags = '0;
    flags[`SET_DB_TO_DATA] = pb[`SET_DB_TO_DATA];
    flags[`SET_DB_TO_ACC] = pb[`SET_DB_TO_ACC];
    flags[`SET_DB_TO_ALU] = pb[`SET_DB_TO_ALU];
    flags[`SET_SB_TO_X] = pb[`SET_SB_TO_X];
    flags[`SET_SB_TO_ACC] = pb[`SET_SB_TO_ACC];
    flags[`SET_SB_TO_ADH] = pb[`SET_SB_TO_ADH];
    flags[`SET_SB_TO_DB] = pb[`SET_SB_TO_DB];
    flags[`SET_ADH_TO_DATA] = pb[`SET_ADH_TO_DATA];
    flags[`SET_ADH_FF] = pb[`SET_ADH_FF];
    flags[`SET_ADH_TO_SB] = pb[`SET_ADH_TO_SB];
    flags[`SET_ADL_TO_DB] = pb[`SET_ADL_TO_DB];
    flags[`SET_ADL_TO_SB] = pb[`SET_ADL_TO_SB];
    flags[`LOAD_X] = pb[`LOAD_X];
    flags[`LOAD_ACC] = pb[`LOAD_ACC];
    flags[`LOAD_ABH] = pb[`LOAD_ABH];
    flags[`LOAD_ABL] = pb[`LOAD_ABL];
    flags[`ALU_SUM] = pb[`ALU_SUM];
    flags[`ALU_AND] = pb[`ALU_AND];
    flags[`ALU_OR] = pb[`ALU_OR];
    flags[`ALU_XOR] = pb[`ALU_XOR];
    flags[`ALU_CARRY_IN] = pb[`ALU_CARRY_IN];
  end

  // address registers on the leds, dor on uart tx
  internalDataflow dataflow (
    .hwclk(hwclk),
    .rstN(rstN),
    .flags(flags),
    .externalDBRead(rxdata),
    .externalAddressBusHighOutput(left),
    .externalAddressBusLowOutput(right),
    .externalDBWrite(txdata),
    .carry(red),
    .accSign(green)
  );

  interruptInjector injector (
    .hwclk(hwclk),
    .rstN(rstN),
    .nonMaskableInterrupt(nmi),
    .interruptRequest(irq),
    .processStatusRegIFlag(iFlag),
    .interruptAcknowledged(ack),
    .irqGenerated(irqGenerated),
    .nmiGenerated(nmiGenerated),
    .nmiRunning(nmiRunning),
    .resetRunning(blue)
  );

endmodule

/* bench/dataflow_props.sv */
`timescale 1ns/1ps

module dataflowProps
  import interruptPkg::*;
(
  input logic hwclk,
  input logic rstN,
  input injStateT state,
  input logic processStatusRegIFlag,
  input logic irqGenerated,
  input logic nmiRunning,
  input logic resetRunning
);

  // injector sits in reset tracking while reset is held
  resetTracked: assert property (@(posedge hwclk) !rstN |-> resetRunning)
    else $error("resetRunning low while rstN is low");

  // an nmi can only run after the reset ack
  nmiAfterReset: assert property (@(posedge hwclk) nmiRunning |-> state != RESET_PENDING)
    else $error("nmiRunning high in RESET_PENDING");

  // masked irq never shows up
  irqMasked: assert property (@(posedge hwclk) $rose(irqGenerated) |-> !processStatusRegIFlag)
    else $error("irqGenerated rose with the I flag set");

endmodule

/* bench/top_tb.sv */
`timescale 1ns/1ps

`include "dataflow_consts.svh"

module topTb
  import dataflowPkg::*;
();

  logic hwclk;
  logic rstN;
  logic [`FLAG_COUNT-1:0] pb;
  busByteT rxdata;
  logic nmi;
  logic irq;
  logic iFlag;
  logic ack;
  busByteT left;
  busByteT right;
  busByteT txdata;
  logic red;
  logic green;
  logic blue;
  logic irqGenerated;
  logic nmiGenerated;
  logic nmiRunning;
  int errors;
  int checks;
  logic [15:0] lfsr;

  top top_inst (.*);

  // assertions ride on the injector
  bind interruptInjector dataflowProps props (
    .hwclk(hwclk),
    .rstN(rstN),
    .state(state),
    .processStatusRegIFlag(processStatusRegIFlag),
    .irqGenerated(irqGenerated),
    .nmiRunning(nmiRunning),
    .resetRunning(resetRunning)
  );

  initial begin
    hwclk = 1'b0;
    forever #20 hwclk = ~hwclk;
  end

  function automatic logic [`FLAG_COUNT-1:0] bitOf(input int index);
    return {{(`FLAG_COUNT-1){1'b0}}, 1'b1} << index;
  endfunction

  // galois lfsr, taps 16,14,13,11
  function automatic logic [15:0] lfsrShift(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic nextRandomByte(output busByteT value);
    for (int i = 0; i < `DATA_WIDTH; i++) begin
      lfsr = lfsrShift(lfsr);
      value[i] = lfsr[0];
    end
  endtask

  // flags held for one rising edge, driven on the falling edge
  task automatic driveCycle(input logic [`FLAG_COUNT-1:0] flagBits, input busByteT data);
    @(negedge hwclk);
    pb = flagBits;
    rxdata = data;
  endtask

  task automatic compareValue(input string name, input busByteT actual, input busByteT expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s is %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic pulseAck();
    @(negedge hwclk);
    ack = 1'b1;
    @(negedge hwclk);
    ack = 1'b0;
  endtask

  task automatic waitNmiGenerated(input int limit);
    int cycles;
    cycles = 0;
    while (nmiGenerated !== 1'b1 && cycles < limit) begin
      @(negedge hwclk);
      cycles++;
    end
    if (nmiGenerated !== 1'b1) begin
      errors++;
      $display("nmiGenerated did not rise within %0d cycles of the nmi edge", limit);
    end
  endtask

  task automatic resetValues();
    compareValue("left", left, 8'h00);
    compareValue("right", right, 8'h00);
    compareValue("txdata", txdata, 8'h00);
    compareValue("red", red, 1'b0);
    compareValue("blue", blue, 1'b1);
  endtask

  task automatic busRouting();
    busByteT value;
    busByteT other;
    nextRandomByte(value);
    other = {1'b0, value[6:0]};
    // rxdata over db and sb into acc, then acc over sb and adh into abh
    driveCycle(bitOf(`SET_DB_TO_DATA) | bitOf(`SET_SB_TO_DB) | bitOf(`LOAD_ACC), value);
    driveCycle(bitOf(`SET_SB_TO_ACC) | bitOf(`SET_ADH_TO_SB) | bitOf(`LOAD_ABH), 8'h00);
    driveCycle('0, 8'h00);
    compareValue("left", left, value);
    compareValue("green", green, value[7]);
    driveCycle(bitOf(`SET_ADH_FF) | bitOf(`LOAD_ABH), 8'h00);
    driveCycle('0, 8'h00);
    compareValue("left", left, 8'hFF);
    // adl left undriven
    driveCycle(bitOf(`LOAD_ABL), 8'h00);
    driveCycle('0, 8'h00);
    compareValue("right", right, `PRECHARGE_VALUE);
    driveCycle(bitOf(`SET_ADH_TO_DATA) | bitOf(`LOAD_ABH), other);
    driveCycle('0, 8'h00);
    compareValue("left", left, other);
    // sb and adh feeding each other, adh falls back to precharge
    driveCycle(bitOf(`SET_SB_TO_ADH) | bitOf(`SET_ADH_TO_SB) | bitOf(`LOAD_ABH), 8'h00);
    driveCycle('0, 8'h00);
    compareValue("left", left, `PRECHARGE_VALUE);
  endtask

  task automatic sourcePriority();
    busByteT value;
    nextRandomByte(value);
    driveCycle(bitOf(`SET_DB_TO_DATA) | bitOf(`SET_SB_TO_DB) | bitOf(`LOAD_ACC), ~value);
    // rxdata and acc both on db, rxdata must win
    driveCycle(bitOf(`SET_DB_TO_DATA) | bitOf(`SET_DB_TO_ACC) | bitOf(`SET_SB_TO_DB)
      | bitOf(`LOAD_ACC) | bitOf(`SET_ADL_TO_DB) | bitOf(`LOAD_ABL), value);
    driveCycle(bitOf(`SET_DB_TO_ACC), 8'h00);
    driveCycle('0, 8'h00);
    compareValue("right", right, value);
    compareValue("txdata", txdata, value);
  endtask

  task automatic aluStep(input logic [`FLAG_COUNT-1:0] opFlags, input busByteT expResult,
                         input logic expCarry);
    // x on sb, acc on db
    driveCycle(bitOf(`SET_SB_TO_X) | bitOf(`SET_DB_TO_ACC) | opFlags, 8'h00);
    driveCycle(bitOf(`SET_DB_TO_ALU), 8'h00);
    driveCycle('0, 8'h00);
    compareValue("txdata", txdata, expResult);
    compareValue("red", red, expCarry);
  endtask

  task automatic aluOperations();
    busByteT xv;
    busByteT av;
    logic [`DATA_WIDTH:0] wide;
    nextRandomByte(xv);
    nextRandomByte(av);
    driveCycle(bitOf(`SET_DB_TO_DATA) | bitOf(`SET_SB_TO_DB) | bitOf(`LOAD_X), xv);
    driveCycle(bitOf(`SET_DB_TO_DATA) | bitOf(`SET_SB_TO_DB) | bitOf(`LOAD_ACC), av);
    wide = {1'b0, xv} + {1'b0, av} + 9'd1;
    aluStep(bitOf(`ALU_SUM) | bitOf(`ALU_CARRY_IN), wide[7:0], wide[8]);
    aluStep(bitOf(`ALU_AND), xv & av, 1'b0);
    wide = {1'b0, xv} + {1'b0, av};
    aluStep(bitOf(`ALU_SUM), wide[7:0], wide[8]);
    aluStep(bitOf(`ALU_OR), xv | av, 1'b0);
    aluStep(bitOf(`ALU_XOR), xv ^ av, 1'b0);
    // and beats or and xor
    aluStep(bitOf(`ALU_AND) | bitOf(`ALU_OR) | bitOf(`ALU_XOR), xv & av, 1'b0);
    // x plus its complement plus carry in wraps to zero with carry out
    driveCycle(bitOf(`SET_DB_TO_DATA) | bitOf(`SET_SB_TO_DB) | bitOf(`LOAD_ACC), ~xv);
    aluStep(bitOf(`ALU_SUM) | bitOf(`ALU_CARRY_IN), 8'h00, 1'b1);
    // complementary bytes xor to all ones, logic op drops the carry
    aluStep(bitOf(`ALU_XOR), 8'hFF, 1'b0);
  endtask

  task automatic interruptFlow();
    pulseAck();
    compareValue("blue", blue, 1'b0);
    @(negedge hwclk);
    nmi = 1'b1;
    waitNmiGenerated(8);
    compareValue("nmiRunning", nmiRunning, 1'b0);
    nmi = 1'b0;
    pulseAck();
    compareValue("nmiRunning", nmiRunning, 1'b1);
    compareValue("nmiGenerated", nmiGenerated, 1'b0);
    irq = 1'b1;
    @(negedge hwclk);
    compareValue("irqGenerated", irqGenerated, 1'b1);
    iFlag = 1'b1;
    @(negedge hwclk);
    compareValue("irqGenerated", irqGenerated, 1'b0);
    irq = 1'b0;
    iFlag = 1'b0;
    pulseAck();
    compareValue("nmiRunning", nmiRunning, 1'b0);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    lfsr = 16'd46075;
    rstN = 1'b0;
    pb = '0;
    rxdata = '0;
    nmi = 1'b0;
    irq = 1'b0;
    iFlag = 1'b0;
    ack = 1'b0;
    repeat (3) @(negedge hwclk);
    rstN = 1'b1;
    resetValues();
    busRouting();
    sourcePriority();
    aluOperations();
    interruptFlow();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
source/dataflowPkg.sv
source/interruptPkg.sv
source/internalBus.sv
source/registerBlock.sv
source/alu.sv
source/internalDataflow.sv
source/interruptInjector.sv
source/top.sv
bench/dataflow_props.sv
bench/top_tb.sv
